//--- build.f
verilog/dcache_pkg.sv
verilog/dcache_data_store.sv
verilog/dcache_tag_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/dcache_props.sv
sim/tb_dcache.sv

//--- Makefile
# Verilator build and run of the data cache testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f build.f -o tb_dcache
	./obj_dir/tb_dcache | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_dcache.sv
`default_nettype none
// ----------------------------------------------------------------------
// Testbench for the data cache. Random-latency line memory, a mirror of
// tags, ages and data, a directed eviction run, then LFSR traffic
// ----------------------------------------------------------------------

module tb_dcache;

    localparam int TIMEOUT_CYCLES = 5000;   // 220 requests x 20 cycles, rounded up
    localparam int MEM_WORDS      = 1024;   // 4 KB behind the cache
    localparam int WB             = dcache_pkg::WORD_BITS;

    logic              cpu_clk = 1'b0;
    logic              cpu_rst_n;
    logic              cpu_req;
    logic              cpu_we;
    dcache_pkg::addr_t cpu_addr;
    dcache_pkg::word_t cpu_wdata;
    logic              cpu_ready;
    logic              cpu_valid;
    dcache_pkg::word_t cpu_rdata;
    logic              cpu_hit;
    logic              cpu_miss;
    logic              mem_req;
    logic              mem_we;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::line_t mem_wdata;
    logic              mem_ready = 1'b0;   // Memory side owned by the model
    logic              mem_valid = 1'b0;
    dcache_pkg::line_t mem_rdata = '0;

    dcache_pkg::word_t mem_words [MEM_WORDS];   // Backing store
    dcache_pkg::word_t ref_words [MEM_WORDS];   // Latest value the CPU should see
    dcache_pkg::tag_t  ref_tag   [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
    bit                ref_valid [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
    bit                ref_dirty [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
    int                ref_age   [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];

    logic [15:0]       lfsr = 16'd33;
    bit                exp_wb;           // Dirty victim predicted for this request
    dcache_pkg::addr_t exp_wb_addr;
    dcache_pkg::addr_t exp_fetch_addr;
    bit                wb_seen;
    bit                mem_pending;
    bit                mem_answered;
    int                mem_wait;
    int                req_count = 0;
    int                valid_count = 0;
    int                cycle_count = 0;

    dcache_top i_dcache_top (.*);

    always #50 cpu_clk = ~cpu_clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};   // One step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Tag above bit 7, set in bits 6..4, word in bits 3..2
    function automatic dcache_pkg::addr_t line_addr(input int tag, input int set, input int word);
        return dcache_pkg::addr_t'((tag << 7) | (set << 4) | (word << 2));
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s = %h, expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("ERROR: %s", what);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    // Lowest empty way, else oldest with the lower way on ties
    function automatic int pick_victim(input int set);
        int v;
        v = 0;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (!ref_valid[set][w]) return w;
        end
        for (int w = 1; w < dcache_pkg::NUM_WAYS; w++) begin
            if (ref_age[set][w] > ref_age[set][v]) v = w;
        end
        return v;
    endfunction

    task automatic touch_way(input int set, input int way);
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (w == way) ref_age[set][w] = 0;
            else if (ref_valid[set][w] && ref_age[set][w] < dcache_pkg::AGE_MAX)
                ref_age[set][w]++;
        end
    endtask

    // One CPU access, issued after a rising edge, ends at the completing negedge
    task automatic run_request(input logic we, input dcache_pkg::addr_t addr,
                               input dcache_pkg::word_t wdata);
        int               set;
        int               way;
        int               wi;
        bit               hit_exp;
        dcache_pkg::tag_t tag;
        set = int'(addr[6:4]);
        wi  = int'(addr[11:2]);
        tag = addr[31:7];
        way = -1;
        for (int w = dcache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) way = w;
        end
        hit_exp = (way >= 0);
        if (!hit_exp) way = pick_victim(set);
        exp_wb         = !hit_exp && ref_valid[set][way] && ref_dirty[set][way];
        exp_wb_addr    = {ref_tag[set][way], addr[6:4], 4'h0};
        exp_fetch_addr = {addr[31:4], 4'h0};
        wb_seen        = 1'b0;

        @(posedge cpu_clk);
        #10;
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        @(negedge cpu_clk);
        check_true(cpu_ready, "cache not ready for a new request");
        @(posedge cpu_clk);               // Accepted here
        #10;
        req_count++;
        cpu_req = 1'b0;
        @(negedge cpu_clk);
        check_value("cpu_hit", cpu_hit, hit_exp);
        check_value("cpu_miss", cpu_miss, !hit_exp);
        check_value("cpu_valid", cpu_valid, hit_exp);
        while (!cpu_valid) @(negedge cpu_clk);   // Miss waits on memory
        if (!we) check_value("cpu_rdata", cpu_rdata, ref_words[wi]);
        check_value("write-back done", wb_seen, exp_wb);

        touch_way(set, way);               // Mirror update
        if (!hit_exp) begin
            ref_tag[set][way]   = tag;
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = we;
        end else if (we) begin
            ref_dirty[set][way] = 1'b1;
        end
        if (we) ref_words[wi] = wdata;
    endtask

    // Line memory, 0 to 7 wait cycles per request
    always begin : memory_model
        logic [31:0] lat;
        int          base;
        @(posedge cpu_clk);
        #10;
        if (mem_answered) begin            // Completed on this edge
            mem_ready    = 1'b0;
            mem_valid    = 1'b0;
            mem_answered = 1'b0;
            mem_pending  = 1'b0;
        end
        if (cpu_rst_n && mem_req && !mem_pending) begin
            take_bits(3, lat);
            mem_wait    = int'(lat);
            mem_pending = 1'b1;
        end
        if (mem_pending && mem_wait > 0) begin
            mem_wait--;
        end else if (mem_pending) begin
            base = int'(mem_addr[11:2]);
            if (mem_we) begin
                check_true(exp_wb, "memory write issued without a dirty victim");
                check_value("mem_addr", mem_addr, exp_wb_addr);
                for (int k = 0; k < 4; k++) begin
                    check_value("mem_wdata word", mem_wdata[k*WB +: WB], ref_words[base + k]);
                    mem_words[base + k] = mem_wdata[k*WB +: WB];
                end
                wb_seen   = 1'b1;
                mem_ready = 1'b1;
            end else begin
                check_value("mem_addr", mem_addr, exp_fetch_addr);
                for (int k = 0; k < 4; k++) mem_rdata[k*WB +: WB] = mem_words[base + k];
                mem_valid = 1'b1;
            end
            mem_answered = 1'b1;
        end
    end

    always @(negedge cpu_clk) begin
        if (cpu_valid) valid_count++;
    end

    always @(posedge cpu_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, the cache stopped completing requests");
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        logic [31:0] r_we;
        logic [31:0] r_line;
        logic [31:0] r_word;
        logic [31:0] r_data;
        cpu_rst_n = 1'b0;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = 32'hC0DE0000 ^ (i << 2);   // Byte address in low bits
            ref_words[i] = mem_words[i];
        end
        for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_age[s][w]   = 0;
            end
        end
        repeat (8) @(posedge cpu_clk);
        #10 cpu_rst_n = 1'b1;

        // Five lines in set 3, fifth one forces dirty evictions
        for (int t = 0; t < 5; t++) run_request(1'b1, line_addr(20 + t, 3, t), 32'hD00D0000 + t);
        for (int t = 0; t < 5; t++) run_request(1'b0, line_addr(20 + t, 3, t), '0);
        for (int t = 4; t >= 0; t--) run_request(1'b0, line_addr(20 + t, 3, 0), '0);

        // 16 lines, 8 tags each in sets 0 and 5
        for (int n = 0; n < 200; n++) begin
            take_bits(1, r_we);
            take_bits(4, r_line);
            take_bits(2, r_word);
            take_bits(32, r_data);
            run_request(r_we[0], line_addr(r_line[3:1], r_line[0] ? 5 : 0, r_word), r_data);
        end

        @(posedge cpu_clk);                // Let the last valid be counted
        if (valid_count == req_count) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("CHECK FAILED: valid_count = %h, expected %h", valid_count, req_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "completion count mismatch");
        end
    end

endmodule

`default_nettype wire

//--- sim/dcache_props.sv
`default_nettype none
// ----------------------------------------------------------------------
// Concurrent checks on the CPU and memory handshakes of the data cache.
// Bound into every dcache_top instance by the bind at the bottom
// ----------------------------------------------------------------------

module dcache_props (
    input  logic               cpu_clk,
    input  logic               cpu_rst_n,
    input  logic               cpu_req,
    input  logic               cpu_ready,
    input  logic               cpu_valid,
    input  logic               cpu_hit,
    input  logic               cpu_miss,
    input  logic               mem_req,
    input  logic               mem_we,
    input  dcache_pkg::addr_t  mem_addr,
    input  dcache_pkg::line_t  mem_wdata,
    input  logic               mem_ready,
    input  logic               mem_valid
);

    // Quiet outputs on the first edge out of reset
    assert property (@(posedge cpu_clk) $rose(cpu_rst_n)
        |-> cpu_ready && !cpu_valid && !cpu_hit && !cpu_miss && !mem_req)
        else $error("cache outputs not quiet after reset");

    // Memory request held until write ready or read valid
    assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        mem_req && !(mem_we ? mem_ready : mem_valid)
        |=> mem_req && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory request changed before completion");

    assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        mem_req |-> mem_addr[3:0] == 4'h0)   // Whole lines only
        else $error("memory address not line aligned");

    // Busy from acceptance until the single cpu_valid
    assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        cpu_req && cpu_ready |=> !cpu_ready)
        else $error("cache still ready after accepting a request");

    assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        !cpu_ready && !cpu_valid |=> !cpu_ready)
        else $error("cache became ready without completing");

    assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        cpu_valid |-> !cpu_ready)
        else $error("completion seen while idle");

    assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        cpu_valid |=> cpu_ready && !cpu_valid)   // One pulse, then idle
        else $error("completion not followed by idle");

    assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        !(cpu_hit && cpu_miss) && (!cpu_hit || cpu_valid))
        else $error("hit and miss flags inconsistent");

endmodule

bind dcache_top dcache_props i_dcache_props (.*);

`default_nettype wire

//--- verilog/dcache_top.sv
`default_nettype none
// ----------------------------------------------------------------------
// Data cache top level. Connects the controller, tag store and data
// store between the CPU word port and the memory line port
// ----------------------------------------------------------------------

module dcache_top (
    input  logic                 cpu_clk,
    input  logic                 cpu_rst_n,
    // CPU side
    input  logic                 cpu_req,
    input  logic                 cpu_we,
    input  dcache_pkg::addr_t    cpu_addr,
    input  dcache_pkg::word_t    cpu_wdata,
    output logic                 cpu_ready,
    output logic                 cpu_valid,
    output dcache_pkg::word_t    cpu_rdata,
    output logic                 cpu_hit,
    output logic                 cpu_miss,
    // Memory side
    output logic                 mem_req,
    output logic                 mem_we,
    output dcache_pkg::addr_t    mem_addr,
    output dcache_pkg::line_t    mem_wdata,
    input  logic                 mem_ready,
    input  logic                 mem_valid,
    input  dcache_pkg::line_t    mem_rdata
);

    dcache_pkg::index_t    req_index;
    dcache_pkg::tag_t      req_tag;
    dcache_pkg::word_ofs_t req_word_ofs;
    dcache_pkg::way_t      sel_way;      // Way being read or written
    logic                  req_we;
    dcache_pkg::word_t     req_wdata;
    logic                  hit_update;   // Hit in LOOKUP
    logic                  refill_update;  // Line arriving from memory

    logic                  hit;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::way_t      victim_way;
    logic                  victim_dirty;
    dcache_pkg::tag_t      victim_tag;
    dcache_pkg::word_t     rd_word;
    dcache_pkg::line_t     victim_line;

    dcache_ctrl i_dcache_ctrl (
        .cpu_clk, .cpu_rst_n,
        .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata,
        .cpu_ready, .cpu_valid, .cpu_rdata, .cpu_hit, .cpu_miss,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ready, .mem_valid,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .rd_word, .victim_line,
        .req_index, .req_tag, .req_word_ofs, .sel_way, .req_we, .req_wdata,
        .hit_update, .refill_update
    );

    dcache_tag_store i_dcache_tag_store (
        .cpu_clk, .cpu_rst_n,
        .req_index, .req_tag, .sel_way, .req_we, .hit_update, .refill_update,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    dcache_data_store i_dcache_data_store (
        .cpu_clk,
        .req_index, .req_word_ofs, .sel_way, .req_we, .req_wdata,
        .hit_update, .refill_update, .mem_rdata,
        .rd_word, .victim_line
    );

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`default_nettype none
// ----------------------------------------------------------------------
// Cache controller. Captures one CPU request, runs the lookup, write-back
// and fetch sequence, drives the memory handshake and the CPU status
// ----------------------------------------------------------------------

module dcache_ctrl (
    input  logic                   cpu_clk,
    input  logic                   cpu_rst_n,
    input  logic                   cpu_req,
    input  logic                   cpu_we,
    input  dcache_pkg::addr_t      cpu_addr,
    input  dcache_pkg::word_t      cpu_wdata,
    output logic                   cpu_ready,
    output logic                   cpu_valid,
    output dcache_pkg::word_t      cpu_rdata,
    output logic                   cpu_hit,
    output logic                   cpu_miss,
    output logic                   mem_req,
    output logic                   mem_we,
    output dcache_pkg::addr_t      mem_addr,
    output dcache_pkg::line_t      mem_wdata,
    input  logic                   mem_ready,
    input  logic                   mem_valid,
    // From tag and data stores
    input  logic                   hit,
    input  dcache_pkg::way_t       hit_way,
    input  dcache_pkg::way_t       victim_way,
    input  logic                   victim_dirty,
    input  dcache_pkg::tag_t       victim_tag,
    input  dcache_pkg::word_t      rd_word,
    input  dcache_pkg::line_t      victim_line,
    // To tag and data stores
    output dcache_pkg::index_t     req_index,
    output dcache_pkg::tag_t       req_tag,
    output dcache_pkg::word_ofs_t  req_word_ofs,
    output dcache_pkg::way_t       sel_way,
    output logic                   req_we,
    output dcache_pkg::word_t      req_wdata,
    output logic                   hit_update,
    output logic                   refill_update
);

    localparam int LINE_OFS_BITS = dcache_pkg::WORD_OFS_BITS + dcache_pkg::BYTE_OFS_BITS;

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    dcache_pkg::addr_t       req_addr_q;   // Captured CPU address
    dcache_pkg::way_t        victim_q;     // Victim frozen when the miss is seen
    logic                    accept;

    assign cpu_ready = (state_q == dcache_pkg::IDLE);
    assign accept    = cpu_req && cpu_ready;

    // Field split of the captured address
    assign req_tag      = req_addr_q[dcache_pkg::ADDR_BITS-1 -: dcache_pkg::TAG_BITS];
    assign req_index    = req_addr_q[LINE_OFS_BITS +: dcache_pkg::INDEX_BITS];
    assign req_word_ofs = req_addr_q[dcache_pkg::BYTE_OFS_BITS +: dcache_pkg::WORD_OFS_BITS];

    // Hit way during lookup, frozen victim through write-back and refill
    assign sel_way   = (state_q == dcache_pkg::LOOKUP) ? hit_way : victim_q;
    assign cpu_rdata = rd_word;        // Store muxes the refill line itself
    assign mem_wdata = victim_line;    // Set is untouched while writing back

    always_ff @(posedge cpu_clk or negedge cpu_rst_n) begin
        if (!cpu_rst_n) begin
            state_q  <= dcache_pkg::IDLE;
            req_we   <= 1'b0;
            victim_q <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                req_we <= cpu_we;
            end
            if (state_q == dcache_pkg::LOOKUP && !hit) begin
                victim_q <= victim_way;
            end
        end
    end

    // Request payload
    always_ff @(posedge cpu_clk) begin
        if (accept) begin
            req_addr_q <= cpu_addr;
            req_wdata  <= cpu_wdata;
        end
    end

    always_comb begin
        state_d       = state_q;
        cpu_valid     = 1'b0;
        cpu_hit       = 1'b0;
        cpu_miss      = 1'b0;
        mem_req       = 1'b0;
        mem_we        = 1'b0;
        mem_addr      = '0;
        hit_update    = 1'b0;
        refill_update = 1'b0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (cpu_req) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                cpu_hit  = hit;
                cpu_miss = !hit;
                if (hit) begin
                    cpu_valid  = 1'b1;     // Hit answers right away
                    hit_update = 1'b1;
                    state_d    = dcache_pkg::IDLE;
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::WRITE_BACK;
                end else begin
                    state_d = dcache_pkg::FETCH;   // Clean or empty victim
                end
            end
            dcache_pkg::WRITE_BACK: begin
                mem_req  = 1'b1;
                mem_we   = 1'b1;
                mem_addr = {victim_tag, req_index, {LINE_OFS_BITS{1'b0}}};
                if (mem_ready) begin
                    state_d = dcache_pkg::FETCH;
                end
            end
            dcache_pkg::FETCH: begin
                mem_req  = 1'b1;
                mem_addr = {req_tag, req_index, {LINE_OFS_BITS{1'b0}}};
                if (mem_valid) begin
                    cpu_valid     = 1'b1;  // Word taken from mem_rdata this cycle
                    refill_update = 1'b1;
                    state_d       = dcache_pkg::IDLE;
                end
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/dcache_tag_store.sv
`default_nettype none
// ----------------------------------------------------------------------
// Tag store. Keeps tag, valid, dirty and age per way, compares all ways
// of the addressed set at once and picks the replacement victim
// ----------------------------------------------------------------------

module dcache_tag_store (
    input  logic                cpu_clk,
    input  logic                cpu_rst_n,
    input  dcache_pkg::index_t  req_index,
    input  dcache_pkg::tag_t    req_tag,
    input  dcache_pkg::way_t    sel_way,
    input  logic                req_we,
    input  logic                hit_update,
    input  logic                refill_update,
    output logic                hit,
    output dcache_pkg::way_t    hit_way,
    output dcache_pkg::way_t    victim_way,
    output logic                victim_dirty,
    output dcache_pkg::tag_t    victim_tag
);

    dcache_pkg::tag_t tag_q   [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
    logic             valid_q [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
    logic             dirty_q [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
    dcache_pkg::age_t age_q   [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];

    logic             found_inv;    // Set has an empty way
    dcache_pkg::age_t oldest;       // Largest age seen so far

    // Parallel compare over the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = dcache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (valid_q[req_index][w] && tag_q[req_index][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = dcache_pkg::way_t'(w);   // Lowest match wins
            end
        end
    end

    // Victim is the first empty way, otherwise the oldest one
    always_comb begin
        found_inv  = 1'b0;
        victim_way = '0;
        oldest     = age_q[req_index][0];
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (!valid_q[req_index][w] && !found_inv) begin
                found_inv  = 1'b1;
                victim_way = dcache_pkg::way_t'(w);
            end
        end
        if (!found_inv) begin
            for (int w = 1; w < dcache_pkg::NUM_WAYS; w++) begin
                if (age_q[req_index][w] > oldest) begin    // Strict, ties keep lower way
                    oldest     = age_q[req_index][w];
                    victim_way = dcache_pkg::way_t'(w);
                end
            end
        end
    end

    assign victim_dirty = valid_q[req_index][victim_way] && dirty_q[req_index][victim_way];
    assign victim_tag   = tag_q[req_index][victim_way];

    // Status bits and ages
    always_ff @(posedge cpu_clk or negedge cpu_rst_n) begin
        if (!cpu_rst_n) begin
            for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                    age_q[s][w]   <= '0;
                end
            end
        end else if (hit_update || refill_update) begin
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                if (dcache_pkg::way_t'(w) == sel_way) begin
                    age_q[req_index][w] <= '0;     // Most recently used
                end else if (valid_q[req_index][w] && age_q[req_index][w] < dcache_pkg::AGE_MAX) begin
                    age_q[req_index][w] <= age_q[req_index][w] + 1'b1;
                end
            end
            if (refill_update) begin
                valid_q[req_index][sel_way] <= 1'b1;
                dirty_q[req_index][sel_way] <= req_we;   // Write-allocate dirties at once
            end else if (req_we) begin
                dirty_q[req_index][sel_way] <= 1'b1;
            end
        end
    end

    // Tags only change on refill
    always_ff @(posedge cpu_clk) begin
        if (refill_update) begin
            tag_q[req_index][sel_way] <= req_tag;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_data_store.sv
`default_nettype none
// ----------------------------------------------------------------------
// Data store. Holds the cache lines, reads the addressed word, writes a
// word on a write hit and a whole, possibly merged, line on refill
// ----------------------------------------------------------------------

module dcache_data_store (
    input  logic                   cpu_clk,
    input  dcache_pkg::index_t     req_index,
    input  dcache_pkg::word_ofs_t  req_word_ofs,
    input  dcache_pkg::way_t       sel_way,
    input  logic                   req_we,
    input  dcache_pkg::word_t      req_wdata,
    input  logic                   hit_update,
    input  logic                   refill_update,
    input  dcache_pkg::line_t      mem_rdata,
    output dcache_pkg::word_t      rd_word,
    output dcache_pkg::line_t      victim_line
);

    dcache_pkg::line_t line_q [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];

    dcache_pkg::line_t src_line;    // Stored line, or the incoming one on refill
    dcache_pkg::line_t wr_line;     // Source with the CPU word merged in
    logic              wr_en;

    assign victim_line = line_q[req_index][sel_way];
    assign src_line    = refill_update ? mem_rdata : victim_line;
    assign rd_word     = src_line[req_word_ofs * dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS];

    always_comb begin
        wr_line = src_line;
        if (req_we) begin
            wr_line[req_word_ofs * dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS] = req_wdata;
        end
    end

    // Refill always writes, a hit only when storing
    assign wr_en = refill_update || (hit_update && req_we);

    always_ff @(posedge cpu_clk) begin
        if (wr_en) begin
            line_q[req_index][sel_way] <= wr_line;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
`default_nettype none
// ----------------------------------------------------------------------
// Shared geometry, field types and controller states for the 4-way
// write-back data cache. Modules refer to these by dcache_pkg:: names
// ----------------------------------------------------------------------

package dcache_pkg;

    // Bus widths
    localparam int ADDR_BITS     = 32;
    localparam int WORD_BITS     = 32;
    localparam int LINE_BITS     = 128;   // Four words per line

    // Cache shape, 8 sets x 4 ways x 16 bytes
    localparam int NUM_WAYS      = 4;
    localparam int NUM_SETS      = 8;

    // Address split, tag | index | word | byte
    localparam int BYTE_OFS_BITS = 2;     // Ignored, accesses are word aligned
    localparam int WORD_OFS_BITS = 2;
    localparam int INDEX_BITS    = 3;
    localparam int TAG_BITS      = ADDR_BITS - INDEX_BITS - WORD_OFS_BITS - BYTE_OFS_BITS;

    // Replacement age counters
    localparam int AGE_BITS      = 2;
    localparam int AGE_MAX       = 3;     // Saturation value

    typedef logic [ADDR_BITS-1:0]        addr_t;
    typedef logic [WORD_BITS-1:0]        word_t;
    typedef logic [LINE_BITS-1:0]        line_t;
    typedef logic [TAG_BITS-1:0]         tag_t;
    typedef logic [INDEX_BITS-1:0]       index_t;
    typedef logic [WORD_OFS_BITS-1:0]    word_ofs_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
    typedef logic [AGE_BITS-1:0]         age_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE,        // Waiting for a CPU request
        LOOKUP,      // Tag compare, hit served here
        WRITE_BACK,  // Dirty victim going out to memory
        FETCH        // Line coming in, refill on completion
    } ctrl_state_e;

endpackage

`default_nettype wire
